//--- bench/sdram_scheduler_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module sdram_scheduler_tb
  import sdram_cmd_pkg::*;
  import sdram_addr_pkg::*;
();

  localparam int GRANT_TIMEOUT = 300;  // Cycles per wait
  localparam int RUN_LIMIT     = 20000;

  logic               INPUT_CLK;
  logic               RST;
  logic               refresh_strobe;
  logic               rand_request;
  logic               rand_we;
  req_addr_t          rand_address;
  logic [`MASK_W-1:0] rand_mask;
  logic               rand_grant;
  logic               bulk_request;
  logic               bulk_we;
  req_addr_t          bulk_address;
  logic [`MASK_W-1:0] bulk_mask;
  logic               bulk_grant;
  sdram_cmd_t         sdram_command;
  logic [`ROW_W-1:0]  sdram_address;
  logic [`BANK_W-1:0] sdram_bank;
  logic [`MASK_W-1:0] dm_mask;

  integer             seed;
  int                 errors;
  int                 tests_run;
  int                 tests_passed;
  logic               quiet;  // No activity expected

  // Reference model of the open page
  sdram_cmd_t         prev_cmd;
  logic               model_open;
  logic [`PAGE_W-1:0] model_page;
  logic               ack_level;
  logic               refresh_pending;
  int                 actv_count;
  int                 prch_count;
  int                 arsr_count;
  int                 access_count;

  sdram_scheduler DUT (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_request   (rand_request),
    .rand_we        (rand_we),
    .rand_address   (rand_address),
    .rand_mask      (rand_mask),
    .rand_grant     (rand_grant),
    .bulk_request   (bulk_request),
    .bulk_we        (bulk_we),
    .bulk_address   (bulk_address),
    .bulk_mask      (bulk_mask),
    .bulk_grant     (bulk_grant),
    .sdram_command  (sdram_command),
    .sdram_address  (sdram_address),
    .sdram_bank     (sdram_bank),
    .dm_mask        (dm_mask)
  );

  always #20 INPUT_CLK = ~INPUT_CLK;

  function automatic req_addr_t make_addr(input logic [`ROW_W-1:0] row,
                                          input logic [`BANK_W-1:0] bank,
                                          input logic [`COL_W-1:0] col);
    req_addr_t a;
    a.rbc.row  = row;
    a.rbc.bank = bank;
    a.rbc.col  = col;
    return a;
  endfunction

  // Bus carries the column doubled
  function automatic logic [`ROW_W-1:0] col_bus(input logic [`COL_W-1:0] col);
    logic [`ROW_W-1:0] wide;
    wide = col;
    return wide * 2;
  endfunction

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input int num, input string name, input int errors_before);
    tests_run = tests_run + 1;
    if (errors == errors_before)
    begin
      tests_passed = tests_passed + 1;
      $display("Test %0d %s: passed", num, name);
    end
    else
      $display("Test %0d %s: failed", num, name);
  endtask

  // --------------------
  // Reference model
  // --------------------
  always @(posedge INPUT_CLK)
  begin
    prev_cmd <= sdram_command;
    if (RST)
    begin
      model_open   <= 1'b0;
      model_page   <= '0;
      ack_level    <= refresh_strobe;
      actv_count   <= 0;
      prch_count   <= 0;
      arsr_count   <= 0;
      access_count <= 0;
    end
    else
    begin
      case (sdram_command)
        ACTV:
        begin
          model_open <= 1'b1;
          model_page <= {sdram_address, sdram_bank};  // Row then bank
          actv_count <= actv_count + 1;
        end
        PRCH:
        begin
          model_open <= 1'b0;
          prch_count <= prch_count + 1;
        end
        ARSR:
        begin
          ack_level  <= refresh_strobe;
          arsr_count <= arsr_count + 1;
        end
        READ, WRTE: access_count <= access_count + 1;
        default: ;
      endcase
    end
  end

  assign refresh_pending = (refresh_strobe != ack_level);

  // --------------------
  // Assertions
  // --------------------
  no_back_to_back: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command != NOOP) |-> (prev_cmd == NOOP))
    else report_error("two commands on adjacent cycles");

  quiet_bus: assert property (@(posedge INPUT_CLK) disable iff (RST)
    quiet |-> (sdram_command == NOOP && !rand_grant && !bulk_grant))
    else report_error("activity with no request");

  single_grant: assert property (@(posedge INPUT_CLK) disable iff (RST)
    !(rand_grant && bulk_grant))
    else report_error("both grants high");

  access_has_grant: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command == READ || sdram_command == WRTE) |-> (rand_grant || bulk_grant))
    else report_error("access without grant");

  rand_access: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant |-> (sdram_command == (rand_we ? WRTE : READ) &&
                    sdram_address == col_bus(rand_address.rbc.col) &&
                    sdram_bank == rand_address.rbc.bank))
    else report_error("random grant with wrong command, column or bank");

  bulk_access: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_grant |-> (sdram_command == (bulk_we ? WRTE : READ) &&
                    sdram_address == col_bus(bulk_address.rbc.col) &&
                    sdram_bank == bulk_address.rbc.bank))
    else report_error("bulk grant with wrong command, column or bank");

  write_mask: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command == WRTE) |->
      (dm_mask == (bulk_grant ? bulk_mask : rand_mask)))
    else report_error("dm_mask differs from the granted mask");

  access_page: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (rand_grant || bulk_grant) |->
      (model_open && !refresh_pending &&
       model_page == (bulk_grant ? bulk_address.pc.page : rand_address.pc.page)))
    else report_error("access outside the open page or during refresh");

  prch_addr: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command == PRCH) |-> (model_open && sdram_address == 14'h0400))
    else report_error("PRCH with no open page or wrong address");

  actv_addr: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command == ACTV) |->
      (!model_open && !refresh_pending &&
       sdram_address == (bulk_request ? bulk_address.rbc.row : rand_address.rbc.row) &&
       sdram_bank == (bulk_request ? bulk_address.rbc.bank : rand_address.rbc.bank)))
    else report_error("ACTV over an open page or with wrong row or bank");

  arsr_closed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (sdram_command == ARSR) |-> !model_open)
    else report_error("ARSR with a page open");

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic wait_grant(input bit use_bulk);
    int  n;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < GRANT_TIMEOUT)
    begin
      @(posedge INPUT_CLK);
      seen = use_bulk ? bulk_grant : rand_grant;
      n    = n + 1;
    end
    if (!seen)
    begin
      errors = errors + 1;
      $display("Timeout: no grant on the %s port", use_bulk ? "bulk" : "random");
    end
  endtask

  task automatic do_access(input bit use_bulk, input bit we, input req_addr_t addr,
                           input logic [`MASK_W-1:0] mask);
    @(posedge INPUT_CLK);
    if (use_bulk)
    begin
      bulk_we      <= we;
      bulk_address <= addr;
      bulk_mask    <= mask;
      bulk_request <= 1'b1;
    end
    else
    begin
      rand_we      <= we;
      rand_address <= addr;
      rand_mask    <= mask;
      rand_request <= 1'b1;
    end
    wait_grant(use_bulk);
    if (use_bulk)
      bulk_request <= 1'b0;  // Cycle after grant
    else
      rand_request <= 1'b0;
    repeat (3) @(posedge INPUT_CLK);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    integer             r;
    int                 e0;
    int                 a0;
    int                 p0;
    int                 f0;
    int                 w0;
    int                 n;
    bit                 seen;
    req_addr_t          addr;
    req_addr_t          addr_b;
    logic [`PAGE_W-1:0] cur_page;
    INPUT_CLK      = 1'b0;
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_request   = 1'b0;
    rand_we        = 1'b0;
    rand_address   = '0;
    rand_mask      = '0;
    bulk_request   = 1'b0;
    bulk_we        = 1'b0;
    bulk_address   = '0;
    bulk_mask      = '0;
    quiet          = 1'b0;
    errors         = 0;
    tests_run      = 0;
    tests_passed   = 0;
    seed           = 32'h354d_4ee0;
    repeat (8) @(posedge INPUT_CLK);
    RST <= 1'b0;

    e0 = errors;
    quiet <= 1'b1;
    repeat (20) @(posedge INPUT_CLK);
    quiet <= 1'b0;
    end_test(1, "idle after reset", e0);

    e0   = errors;
    a0   = actv_count;
    w0   = access_count;
    addr = make_addr(14'h1a5c, 3'd5, 9'h07f);
    do_access(1'b0, 1'b0, addr, 4'h0);
    assert (actv_count == a0 + 1 && access_count == w0 + 1)
      else report_error("closed-bank read needs one ACTV and one READ");
    end_test(2, "random read on a closed bank", e0);

    e0   = errors;
    w0   = access_count;
    p0   = prch_count;
    a0   = actv_count;
    addr = make_addr(14'h1a5c, 3'd5, 9'h123);  // Same page
    do_access(1'b1, 1'b1, addr, 4'ha);
    assert (access_count == w0 + 1 && prch_count == p0 && actv_count == a0)
      else report_error("bulk write to the open page not issued once as a hit");
    end_test(3, "bulk write", e0);

    e0       = errors;
    cur_page = addr.pc.page;
    for (int i = 0; i < 10; i++)
    begin
      r    = $random(seed);
      addr = make_addr(r[13:0], r[16:14], r[25:17]);
      if (r[29:28] == 2'b00)
        addr.pc.page = cur_page;  // Some page hits
      p0 = prch_count;
      a0 = actv_count;
      do_access(r[30], r[31], addr, r[3:0]);
      if (addr.pc.page != cur_page)
      begin
        assert (prch_count == p0 + 1 && actv_count == a0 + 1)
          else report_error("page miss without one PRCH and one ACTV");
      end
      else
      begin
        assert (prch_count == p0 && actv_count == a0)
          else report_error("page hit caused PRCH or ACTV");
      end
      cur_page = addr.pc.page;
    end
    end_test(4, "page miss with random addresses", e0);

    e0 = errors;
    f0 = arsr_count;
    p0 = prch_count;
    a0 = actv_count;
    @(posedge INPUT_CLK);
    refresh_strobe <= ~refresh_strobe;
    addr.rbc.col = 9'h0aa;  // Would hit the open page
    do_access(1'b0, 1'b0, addr, 4'h5);
    assert (arsr_count == f0 + 1 && prch_count == p0 + 1 && actv_count == a0 + 1)
      else report_error("refresh did not close the page and reopen it");
    end_test(5, "refresh", e0);

    e0     = errors;
    r      = $random(seed);
    addr   = make_addr(r[13:0], r[16:14], r[25:17]);
    addr_b = addr;
    addr_b.rbc.row = addr.rbc.row ^ 14'h0001;
    @(posedge INPUT_CLK);
    bulk_we      <= 1'b1;
    bulk_address <= addr;
    bulk_mask    <= 4'h3;
    bulk_request <= 1'b1;
    rand_we      <= 1'b0;
    rand_address <= addr_b;
    rand_request <= 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < GRANT_TIMEOUT)
    begin
      @(posedge INPUT_CLK);
      seen = bulk_grant || rand_grant;
      n    = n + 1;
    end
    if (!seen)
    begin
      errors = errors + 1;
      $display("Timeout: no grant with both ports requesting");
    end
    assert (bulk_grant && !rand_grant)
      else report_error("random port granted before bulk port");
    bulk_request <= 1'b0;
    wait_grant(1'b0);
    rand_request <= 1'b0;
    repeat (3) @(posedge INPUT_CLK);
    end_test(6, "bulk priority", e0);

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Hard stop if the sequence stalls
  initial
  begin
    repeat (RUN_LIMIT) @(posedge INPUT_CLK);
    $display("Simulation stopped because the cycle limit was reached");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/bank_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module bank_state
  import sdram_cmd_pkg::*;
  import sdram_addr_pkg::*;
(
  input  wire                INPUT_CLK,
  input  wire                RST,
  input  wire                refresh_strobe,
  input  wire sdram_cmd_t    issued_cmd,
  input  wire                stroke,
  input  wire req_addr_t     sel_address,
  input  wire req_addr_t     rand_address,
  input  wire                rand_request,
  input  wire req_addr_t     bulk_address,
  input  wire                bulk_request_q,
  output logic               page_open,
  output logic [`PAGE_W-1:0] open_page,
  output logic               last_was_write,
  output logic               refresh_due,
  output logic               rand_hit,
  output logic               bulk_hit
);

  logic [`PAGE_W-1:0] pending_page;
  logic               strobe_ack;
  logic               page_ready;

  // Page the ACTV decision was made for
  always_ff @(posedge INPUT_CLK)
  begin
    pending_page <= sel_address.pc.page;
    if (stroke && (issued_cmd == ACTV))
      open_page <= pending_page;
  end

  // --------------------
  // State update after each command
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_open      <= 1'b0;
      last_was_write <= 1'b0;
      strobe_ack     <= refresh_strobe;
      refresh_due    <= 1'b0;
    end
    else
    begin
      refresh_due <= strobe_ack ^ refresh_strobe;  // Any toggle since last ARSR
      if (stroke)
      begin
        case (issued_cmd)
          ACTV: page_open <= 1'b1;
          PRCH: page_open <= 1'b0;
          ARSR: strobe_ack <= refresh_strobe;
          default: ;
        endcase
        if (issued_cmd == WRTE)
          last_was_write <= 1'b1;
        else if (issued_cmd != NOOP)
          last_was_write <= 1'b0;
      end
    end
  end

  // --------------------
  // Page compare
  // --------------------
  // Flags stay low right after a command, while the state above settles
  assign page_ready = page_open && !refresh_due && !stroke;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_hit <= 1'b0;
      bulk_hit <= 1'b0;
    end
    else
    begin
      rand_hit <= page_ready && rand_request &&
                  (rand_address.pc.page == open_page);
      bulk_hit <= page_ready && bulk_request_q &&
                  (bulk_address.pc.page == open_page);
    end
  end

endmodule

`default_nettype wire

//--- hdl/command_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module command_issue
  import sdram_cmd_pkg::*;
  import sdram_addr_pkg::*;
(
  input  wire                INPUT_CLK,
  input  wire                RST,
  input  wire                rand_request_q,
  input  wire                bulk_request_q,
  input  wire                sel_we,
  input  wire req_addr_t     sel_address,
  input  wire [`MASK_W-1:0]  sel_mask,
  input  wire                bulk_wins,
  input  wire                page_open,
  input  wire [`PAGE_W-1:0]  open_page,
  input  wire                last_was_write,
  input  wire                refresh_due,
  input  wire                rand_hit,
  input  wire                bulk_hit,
  input  wire                may_issue,
  input  wire                act_aged,
  output sdram_cmd_t         sdram_command,
  output logic [`ROW_W-1:0]  sdram_address,
  output logic [`BANK_W-1:0] sdram_bank,
  output logic [`MASK_W-1:0] dm_mask,
  output logic               rand_grant,
  output logic               bulk_grant,
  output sdram_cmd_t         issued_cmd,
  output logic               stroke
);

  sdram_cmd_t        cmd_q;
  sdram_cmd_t        next_cmd;
  logic [`ROW_W-1:0] next_address;
  logic              hit_sel;
  logic              any_request;
  logic              last_access;
  logic              on_page_ok;
  logic              override_ok;
  logic              issue;

  assign hit_sel     = bulk_wins ? bulk_hit : rand_hit;
  assign any_request = rand_request_q || bulk_request_q;

  // Back-to-back accesses in one direction skip the recovery wait
  assign on_page_ok  = !stroke && last_access && hit_sel && (sel_we == last_was_write);
  assign override_ok = !stroke && may_issue && (any_request || refresh_due);
  assign issue       = on_page_ok || override_ok;

  // --------------------
  // Command and address choice
  // --------------------
  always_comb
  begin
    if (hit_sel)
      next_cmd = sel_we ? WRTE : READ;
    else if (page_open)
      next_cmd = act_aged ? PRCH : NOOP;  // Row still too young to close
    else if (refresh_due)
      next_cmd = ARSR;
    else
      next_cmd = ACTV;
  end

  always_comb
  begin
    if (hit_sel)
      next_address = {{(`ROW_W - `COL_W - 1){1'b0}}, sel_address.rbc.col, 1'b0};
    else if (page_open)
      next_address = `PRCH_ALL_ADDR;
    else
      next_address = sel_address.rbc.row;
  end

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      cmd_q       <= NOOP;
      stroke      <= 1'b0;
      last_access <= 1'b0;
      rand_grant  <= 1'b0;
      bulk_grant  <= 1'b0;
    end
    else
    begin
      stroke     <= issue;
      cmd_q      <= issue ? next_cmd : NOOP;
      rand_grant <= issue && hit_sel && !bulk_wins;
      bulk_grant <= issue && hit_sel && bulk_wins;
      if (issue)
        last_access <= hit_sel;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    sdram_address <= next_address;
    if (hit_sel)
      sdram_bank <= open_page[`BANK_W-1:0];
    else if (!page_open)
      sdram_bank <= sel_address.rbc.bank;  // Kept through PRCH
    if (issue && hit_sel)
      dm_mask <= sel_mask;
  end

  assign sdram_command = cmd_q;
  assign issued_cmd    = cmd_q;

endmodule

`default_nettype wire

//--- hdl/command_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module command_timer
  import sdram_cmd_pkg::*;
(
  input  wire             INPUT_CLK,
  input  wire             RST,
  input  wire sdram_cmd_t issued_cmd,
  input  wire             stroke,
  input  wire             page_hit_any,
  input  wire             page_open,
  input  wire             last_was_write,
  output logic            may_issue,
  output logic            act_aged
);

  localparam logic [`CNT_W-1:0] NORM_THR = 'hd;
  localparam logic [`CNT_W-1:0] DLY_THR  = 'he;  // PRCH after a write

  logic [`CNT_W-1:0] counter;
  logic [2:0]        actv_age;
  logic              extra_pass;
  logic              norm_reached;
  logic              dly_reached;
  logic              may_issue_d;

  // Counter wraps to zero and stops once issue is allowed
  assign norm_reached = (counter >= NORM_THR) || (counter == '0);
  assign dly_reached  = (counter >= DLY_THR) || (counter == '0);

  always_comb
  begin
    if (stroke)
      may_issue_d = 1'b0;
    else if (page_hit_any)
      may_issue_d = norm_reached;
    else if (extra_pass)
      may_issue_d = 1'b0;  // Full lap after refresh
    else if (page_open && last_was_write)
      may_issue_d = dly_reached;
    else
      may_issue_d = norm_reached;
  end

  // --------------------
  // Recovery counter
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      counter    <= `LOAD_IDLE;
      extra_pass <= 1'b0;
      may_issue  <= 1'b0;
    end
    else
    begin
      may_issue <= may_issue_d;
      if (stroke)
      begin
        case (issued_cmd)
          ARSR:    counter <= `LOAD_ARSR;
          ACTV:    counter <= `LOAD_ACTV;
          WRTE:    counter <= `LOAD_WRTE;
          NOOP:    counter <= `LOAD_IDLE;
          default: counter <= `LOAD_OTHER;
        endcase
        if (issued_cmd == ARSR)
          extra_pass <= 1'b1;
      end
      else
      begin
        if (!may_issue)
          counter <= counter + 1'b1;
        if (counter == '0)
          extra_pass <= 1'b0;
      end
    end
  end

  // Minimum row open time
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      actv_age <= 3'h4;
    else if (stroke && (issued_cmd == ACTV))
      actv_age <= 3'h0;
    else if (!actv_age[2])
      actv_age <= actv_age + 1'b1;
  end

  assign act_aged = actv_age[2];

endmodule

`default_nettype wire

//--- hdl/request_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module request_sampler
  import sdram_addr_pkg::*;
(
  input  wire                INPUT_CLK,
  input  wire                RST,
  input  wire                rand_request,
  input  wire                rand_we,
  input  wire req_addr_t     rand_address,
  input  wire [`MASK_W-1:0]  rand_mask,
  input  wire                bulk_request,
  input  wire                bulk_we,
  input  wire req_addr_t     bulk_address,
  input  wire [`MASK_W-1:0]  bulk_mask,
  output logic               rand_request_q,
  output logic               bulk_request_q,
  output logic               sel_we,
  output req_addr_t          sel_address,
  output logic [`MASK_W-1:0] sel_mask,
  output logic               bulk_wins
);

  logic               rand_we_q;
  logic               bulk_we_q;
  req_addr_t          rand_address_q;
  req_addr_t          bulk_address_q;
  logic [`MASK_W-1:0] rand_mask_q;
  logic [`MASK_W-1:0] bulk_mask_q;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_request_q <= 1'b0;
      bulk_request_q <= 1'b0;
    end
    else
    begin
      rand_request_q <= rand_request;
      bulk_request_q <= bulk_request;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_we_q      <= rand_we;
    bulk_we_q      <= bulk_we;
    rand_address_q <= rand_address;
    bulk_address_q <= bulk_address;
    rand_mask_q    <= rand_mask;
    bulk_mask_q    <= bulk_mask;
  end

  assign bulk_wins   = bulk_request_q;  // Bulk port has priority
  assign sel_we      = bulk_wins ? bulk_we_q : rand_we_q;
  assign sel_address = bulk_wins ? bulk_address_q : rand_address_q;
  assign sel_mask    = bulk_wins ? bulk_mask_q : rand_mask_q;

endmodule

`default_nettype wire

//--- hdl/sdram_addr_pkg.sv
`default_nettype none

`include "sdram_defs.svh"

package sdram_addr_pkg;

  // Fields as the command bus needs them
  typedef struct packed {
    logic [`ROW_W-1:0]  row;
    logic [`BANK_W-1:0] bank;
    logic [`COL_W-1:0]  col;
  } rbc_t;

  // Same word split for the page compare
  typedef struct packed {
    logic [`PAGE_W-1:0] page;
    logic [`COL_W-1:0]  col;
  } pc_t;

  typedef union packed {
    rbc_t rbc;
    pc_t  pc;
  } req_addr_t;

endpackage

`default_nettype wire

//--- hdl/sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

  // Encoded as {RAS_n, CAS_n, WE_n}
  typedef enum logic [2:0] {
    MRST = 3'b000,  // Mode register set, never issued
    ARSR = 3'b001,  // Auto refresh
    PRCH = 3'b010,  // Row close
    ACTV = 3'b011,  // Row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // Burst terminate, never issued
    NOOP = 3'b111
  } sdram_cmd_t;

endpackage

`default_nettype wire

//--- hdl/sdram_defs.svh
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// --------------------
// Request address fields
// --------------------
`define ROW_W   14
`define BANK_W  3
`define COL_W   9
`define ADDR_W  26  // ROW_W + BANK_W + COL_W
`define PAGE_W  17  // Row and bank together

`define MASK_W  4   // One bit per 16-bit half of a beat pair

// --------------------
// Recovery counter
// --------------------
`define CNT_W   4

// Load values, counting up toward the issue threshold
`define LOAD_ARSR   4'd3
`define LOAD_ACTV   4'd12
`define LOAD_WRTE   4'd10
`define LOAD_IDLE   4'd14
`define LOAD_OTHER  4'd11

// A10 high selects all banks
`define PRCH_ALL_ADDR 14'h0400

`endif

//--- hdl/sdram_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defs.svh"

module sdram_scheduler
  import sdram_cmd_pkg::*;
  import sdram_addr_pkg::*;
(
  input  wire                INPUT_CLK,
  input  wire                RST,
  input  wire                refresh_strobe,
  input  wire                rand_request,
  input  wire                rand_we,
  input  wire req_addr_t     rand_address,
  input  wire [`MASK_W-1:0]  rand_mask,
  output logic               rand_grant,
  input  wire                bulk_request,
  input  wire                bulk_we,
  input  wire req_addr_t     bulk_address,
  input  wire [`MASK_W-1:0]  bulk_mask,
  output logic               bulk_grant,
  output sdram_cmd_t         sdram_command,
  output logic [`ROW_W-1:0]  sdram_address,
  output logic [`BANK_W-1:0] sdram_bank,
  output logic [`MASK_W-1:0] dm_mask
);

  logic               rand_request_q;
  logic               bulk_request_q;
  logic               sel_we;
  req_addr_t          sel_address;
  logic [`MASK_W-1:0] sel_mask;
  logic               bulk_wins;
  logic               page_open;
  logic [`PAGE_W-1:0] open_page;
  logic               last_was_write;
  logic               refresh_due;
  logic               rand_hit;
  logic               bulk_hit;
  logic               may_issue;
  logic               act_aged;
  sdram_cmd_t         issued_cmd;
  logic               stroke;

  request_sampler u_sampler (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .rand_request   (rand_request),
    .rand_we        (rand_we),
    .rand_address   (rand_address),
    .rand_mask      (rand_mask),
    .bulk_request   (bulk_request),
    .bulk_we        (bulk_we),
    .bulk_address   (bulk_address),
    .bulk_mask      (bulk_mask),
    .rand_request_q (rand_request_q),
    .bulk_request_q (bulk_request_q),
    .sel_we         (sel_we),
    .sel_address    (sel_address),
    .sel_mask       (sel_mask),
    .bulk_wins      (bulk_wins)
  );

  // Hit flags register the raw ports, so they line up with the sampled request
  bank_state u_bank (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .issued_cmd     (issued_cmd),
    .stroke         (stroke),
    .sel_address    (sel_address),
    .rand_address   (rand_address),
    .rand_request   (rand_request),
    .bulk_address   (bulk_address),
    .bulk_request_q (bulk_request),
    .page_open      (page_open),
    .open_page      (open_page),
    .last_was_write (last_was_write),
    .refresh_due    (refresh_due),
    .rand_hit       (rand_hit),
    .bulk_hit       (bulk_hit)
  );

  command_timer u_timer (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .issued_cmd     (issued_cmd),
    .stroke         (stroke),
    .page_hit_any   (rand_hit | bulk_hit),
    .page_open      (page_open),
    .last_was_write (last_was_write),
    .may_issue      (may_issue),
    .act_aged       (act_aged)
  );

  command_issue u_issue (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .rand_request_q (rand_request_q),
    .bulk_request_q (bulk_request_q),
    .sel_we         (sel_we),
    .sel_address    (sel_address),
    .sel_mask       (sel_mask),
    .bulk_wins      (bulk_wins),
    .page_open      (page_open),
    .open_page      (open_page),
    .last_was_write (last_was_write),
    .refresh_due    (refresh_due),
    .rand_hit       (rand_hit),
    .bulk_hit       (bulk_hit),
    .may_issue      (may_issue),
    .act_aged       (act_aged),
    .sdram_command  (sdram_command),
    .sdram_address  (sdram_address),
    .sdram_bank     (sdram_bank),
    .dm_mask        (dm_mask),
    .rand_grant     (rand_grant),
    .bulk_grant     (bulk_grant),
    .issued_cmd     (issued_cmd),
    .stroke         (stroke)
  );

endmodule

`default_nettype wire

//--- sdram_scheduler.f
+incdir+hdl
hdl/sdram_cmd_pkg.sv
hdl/sdram_addr_pkg.sv
hdl/request_sampler.sv
hdl/bank_state.sv
hdl/command_timer.sv
hdl/command_issue.sv
hdl/sdram_scheduler.sv
bench/sdram_scheduler_tb.sv
